//--- hdl/dma_pkg.sv
//////////////////////////////////////////////////
// DMA read path shared definitions
// Word and size widths, bus burst codes, packet
// class and the network flit layout
//////////////////////////////////////////////////

package dma_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Memory word and network flit share one width
  localparam int DMA_DATA_WIDTH = 32;

  // Request size counts words, 1 to 255
  localparam int DMA_SIZE_WIDTH = 8;

  // Network node id width
  localparam int DMA_ID_WIDTH = 5;

  //////////////////////////////////////////////////
  // Bus burst codes
  //////////////////////////////////////////////////

  // Incrementing burst continues after this beat
  localparam logic [2:0] BURST_INCR = 3'b010;
  // This beat terminates the burst
  localparam logic [2:0] BURST_END  = 3'b111;

  // Packet class carried by every DMA data header
  localparam logic [2:0] DMA_CLASS_DMA_DATA = 3'b010;

  //////////////////////////////////////////////////
  // Flit layout
  //////////////////////////////////////////////////

  // Header view, top bit first
  typedef struct packed {
    logic [DMA_ID_WIDTH-1:0]   dest;
    logic [DMA_ID_WIDTH-1:0]   src;
    logic [2:0]                pkt_class;
    logic [DMA_SIZE_WIDTH-1:0] size;
    logic [10:0]               reserved;
  } dma_hdr_t;

  // One flit word, read as header or as raw payload
  typedef union packed {
    dma_hdr_t                  hdr;
    logic [DMA_DATA_WIDTH-1:0] payload;
  } dma_flit_t;

endpackage

//--- hdl/dma_read_fetch.sv
//////////////////////////////////////////////////
// DMA read fetch
// Issues incrementing read bursts on the local
// memory bus and pushes each returned word
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_read_fetch
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_start,
  input  logic [DMA_SIZE_WIDTH-1:0] req_size,
  input  logic [ADDR_WIDTH-1:0]     req_laddr,
  input  logic [DMA_DATA_WIDTH-1:0] bus_rdata,
  input  logic                      bus_ready,
  input  logic                      fifo_ready,
  output logic                      bus_sel,
  output logic                      bus_lock,
  output logic [ADDR_WIDTH-1:0]     bus_addr,
  output logic [2:0]                bus_burst,
  output logic                      push,
  output logic [DMA_DATA_WIDTH-1:0] push_data
);

  //////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  logic [1:0]                state;
  logic [1:0]                state_nxt;

  // Words completed so far in this request
  logic [DMA_SIZE_WIDTH-1:0] word_cnt;
  logic [DMA_SIZE_WIDTH-1:0] word_cnt_nxt;

  // Request fields captured at start
  logic [DMA_SIZE_WIDTH-1:0] size_q;
  logic [ADDR_WIDTH-1:0]     laddr_q;

  logic                      last_word;

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////

  // Current beat is the final word of the request
  assign last_word = (word_cnt == size_q - 1'b1);

  // Select and lock stay up for the whole burst
  assign bus_sel  = (state == ST_DATA);
  assign bus_lock = bus_sel;

  // Word counter scaled to a byte offset
  assign bus_addr = laddr_q + (ADDR_WIDTH'(word_cnt) << 2);

  // Terminate on the last word or when the FIFO nears full
  assign bus_burst = (last_word | ~fifo_ready) ? BURST_END : BURST_INCR;

  // A completed beat goes straight into the FIFO
  assign push      = bus_sel & bus_ready;
  assign push_data = bus_rdata;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt    = state;
    word_cnt_nxt = word_cnt;

    case (state)
      ST_IDLE: begin
        // Start each request from word zero
        word_cnt_nxt = '0;
        if (req_start) begin
          state_nxt = ST_DATA;
        end
      end
      ST_DATA: begin
        if (push) begin
          word_cnt_nxt = word_cnt + 1'b1;
          if (last_word) begin
            state_nxt = ST_IDLE;
          end else if (!fifo_ready) begin
            // Burst was ended, hold off until space frees up
            state_nxt = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        // Restart an incrementing burst at the next word
        if (fifo_ready) begin
          state_nxt = ST_DATA;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      word_cnt <= '0;
    end else begin
      state    <= state_nxt;
      word_cnt <= word_cnt_nxt;
    end
  end

  // Capture size and base address on an accepted start
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_start) begin
      size_q  <= req_size;
      laddr_q <= req_laddr;
    end
  end

endmodule

//--- hdl/dma_word_fifo.sv
//////////////////////////////////////////////////
// DMA word FIFO
// Three-entry shift FIFO with registered head
// and a high-water ready flag
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_word_fifo
  import dma_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  logic [DMA_DATA_WIDTH-1:0] push_data,
  input  logic                      pop,
  output logic [DMA_DATA_WIDTH-1:0] fifo_data,
  output logic                      fifo_empty,
  output logic                      fifo_ready
);

  // Storage, entry zero is always the head
  logic [DMA_DATA_WIDTH-1:0] mem [0:2];

  // One-hot write position
  // bit 0 means empty, bit 3 means all three held
  logic [3:0]                pos;

  assign fifo_data  = mem[0];
  assign fifo_empty = pos[0];

  // High-water mark at two entries
  // leaves room for the beat already in flight
  assign fifo_ready = ~|pos[3:2];

  // Position moves only on push without pop or pop without push
  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push && !pop) begin
      pos <= pos << 1;
    end else if (!push && pop) begin
      pos <= pos >> 1;
    end
  end

  // Shift-down storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (pop) begin
        // Push lands one slot below its old position
        if (push && pos[i+1]) begin
          mem[i] <= push_data;
        end else if (i < 2) begin
          mem[i] <= mem[i+1];
        end
      end else if (push && pos[i]) begin
        mem[i] <= push_data;
      end
    end
  end

endmodule

//--- hdl/dma_noc_packetizer.sv
//////////////////////////////////////////////////
// DMA network packetizer
// Sends one header flit and then the FIFO words
// as payload flits, marking the last one
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_read_packetizer
  import dma_pkg::*;
#(
  parameter int SRC_ID = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_start,
  input  logic [DMA_SIZE_WIDTH-1:0] req_size,
  input  logic [DMA_ID_WIDTH-1:0]   req_dest,
  input  logic [DMA_DATA_WIDTH-1:0] fifo_data,
  input  logic                      fifo_empty,
  input  logic                      noc_ready,
  output logic                      pop,
  output logic                      noc_valid,
  output dma_flit_t                 noc_flit,
  output logic                      noc_last,
  output logic                      busy
);

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_HDR     = 2'd1;
  localparam logic [1:0] ST_PAYLOAD = 2'd2;

  logic [1:0]                state;

  // Payload flits already sent
  logic [DMA_SIZE_WIDTH-1:0] flit_cnt;

  // Request fields held for the packet
  logic [DMA_SIZE_WIDTH-1:0] size_q;
  logic [DMA_ID_WIDTH-1:0]   dest_q;

  logic                      in_payload;
  logic                      last_flit;
  dma_hdr_t                  hdr;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  assign in_payload = (state == ST_PAYLOAD);
  assign last_flit  = (flit_cnt == size_q - 1'b1);
  assign busy       = (state != ST_IDLE);

  // Header is always ready, payload waits for a word
  assign noc_valid = (state == ST_HDR) | (in_payload & ~fifo_empty);
  assign noc_last  = in_payload & ~fifo_empty & last_flit;

  // Head word leaves the FIFO on each payload transfer
  assign pop = in_payload & ~fifo_empty & noc_ready;

  //////////////////////////////////////////////////
  // Flit word
  //////////////////////////////////////////////////

  always_comb begin
    hdr           = '0;
    hdr.dest      = dest_q;
    hdr.src       = DMA_ID_WIDTH'(SRC_ID);
    hdr.pkt_class = DMA_CLASS_DMA_DATA;
    hdr.size      = size_q;
    hdr.reserved  = '0;

    // Payload is taken straight from the FIFO head
    if (state == ST_HDR) begin
      noc_flit.hdr = hdr;
    end else begin
      noc_flit.payload = fifo_data;
    end
  end

  //////////////////////////////////////////////////
  // Packet FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      flit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          flit_cnt <= '0;
          if (req_start) begin
            state <= ST_HDR;
          end
        end
        ST_HDR: begin
          if (noc_ready) begin
            state <= ST_PAYLOAD;
          end
        end
        ST_PAYLOAD: begin
          if (pop) begin
            flit_cnt <= flit_cnt + 1'b1;
            if (last_flit) begin
              state <= ST_IDLE;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Latch size and destination with the start pulse
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_start) begin
      size_q <= req_size;
      dest_q <= req_dest;
    end
  end

endmodule

//--- hdl/dma_read_top.sv
//////////////////////////////////////////////////
// DMA read initiator top
// Bus fetch, word FIFO and network packetizer
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_read_top
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int SRC_ID     = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_start,
  input  logic [DMA_SIZE_WIDTH-1:0] req_size,
  input  logic [ADDR_WIDTH-1:0]     req_laddr,
  input  logic [DMA_ID_WIDTH-1:0]   req_dest,
  input  logic [DMA_DATA_WIDTH-1:0] bus_rdata,
  input  logic                      bus_ready,
  input  logic                      noc_ready,
  output logic                      bus_sel,
  output logic                      bus_lock,
  output logic [ADDR_WIDTH-1:0]     bus_addr,
  output logic [2:0]                bus_burst,
  output logic                      noc_valid,
  output dma_flit_t                 noc_flit,
  output logic                      noc_last,
  output logic                      busy
);

  // Fetch to FIFO
  logic                      push;
  logic [DMA_DATA_WIDTH-1:0] push_data;
  logic                      fifo_ready;

  // FIFO to packetizer
  logic                      pop;
  logic [DMA_DATA_WIDTH-1:0] fifo_data;
  logic                      fifo_empty;

  dma_read_fetch #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .req_start  (req_start),
    .req_size   (req_size),
    .req_laddr  (req_laddr),
    .bus_rdata  (bus_rdata),
    .bus_ready  (bus_ready),
    .fifo_ready (fifo_ready),
    .bus_sel    (bus_sel),
    .bus_lock   (bus_lock),
    .bus_addr   (bus_addr),
    .bus_burst  (bus_burst),
    .push       (push),
    .push_data  (push_data)
  );

  dma_word_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_ready (fifo_ready)
  );

  dma_read_packetizer #(
    .SRC_ID (SRC_ID)
  ) u_packetizer (
    .clk        (clk),
    .rst        (rst),
    .req_start  (req_start),
    .req_size   (req_size),
    .req_dest   (req_dest),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .noc_ready  (noc_ready),
    .pop        (pop),
    .noc_valid  (noc_valid),
    .noc_flit   (noc_flit),
    .noc_last   (noc_last),
    .busy       (busy)
  );

endmodule

//--- dv/dma_read_tb.sv
//////////////////////////////////////////////////
// DMA read initiator testbench
// Memory model, request table, flit and beat
// checks, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_read_tb
  import dma_pkg::*;
();

  localparam int ADDR_WIDTH = 32;
  localparam int SRC_ID     = 3;
  localparam int NUM_ROWS   = 8;

  // Network stall modes
  localparam logic [1:0] MODE_READY  = 2'd0;
  localparam logic [1:0] MODE_RANDOM = 2'd1;
  localparam logic [1:0] MODE_BLOCK  = 2'd2;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]     laddr;
    logic [DMA_SIZE_WIDTH-1:0] size;
    logic [DMA_ID_WIDTH-1:0]   dest;
    logic [1:0]                mode;
  } row_t;

  logic                      clk;
  logic                      rst;
  logic                      req_start;
  logic [DMA_SIZE_WIDTH-1:0] req_size;
  logic [ADDR_WIDTH-1:0]     req_laddr;
  logic [DMA_ID_WIDTH-1:0]   req_dest;
  logic [DMA_DATA_WIDTH-1:0] bus_rdata;
  logic                      bus_ready;
  logic                      noc_ready;
  logic                      bus_sel;
  logic                      bus_lock;
  logic [ADDR_WIDTH-1:0]     bus_addr;
  logic [2:0]                bus_burst;
  logic                      noc_valid;
  dma_flit_t                 noc_flit;
  logic                      noc_last;
  logic                      busy;

  // Per-request bookkeeping
  logic [ADDR_WIDTH-1:0]     cur_laddr;
  logic [1:0]                cur_mode;
  dma_hdr_t                  exp_hdr;
  int                        cur_size;
  int                        beats;
  int                        flits;
  int                        restarts;
  logic                      got_hdr;
  logic                      got_last;
  logic                      mid_drop;
  logic                      prev_sel;
  // Beat completed in the previous cycle and its burst code
  logic                      prev_beat;
  logic [2:0]                prev_burst;

  dma_read_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .SRC_ID     (SRC_ID)
  ) u_dma_read_top (
    .clk (clk), .rst (rst), .req_start (req_start), .req_size (req_size),
    .req_laddr (req_laddr), .req_dest (req_dest), .bus_rdata (bus_rdata),
    .bus_ready (bus_ready), .noc_ready (noc_ready), .bus_sel (bus_sel),
    .bus_lock (bus_lock), .bus_addr (bus_addr), .bus_burst (bus_burst),
    .noc_valid (noc_valid), .noc_flit (noc_flit), .noc_last (noc_last), .busy (busy)
  );

  //////////////////////////////////////////////////
  // Request table
  //////////////////////////////////////////////////

  function automatic row_t table_row(input int idx);
    row_t r;
    case (idx)
      0: r = '{32'h0000_1000, 8'd1,   5'd1,  MODE_READY};
      1: r = '{32'h0000_2004, 8'd4,   5'd7,  MODE_RANDOM};
      2: r = '{32'h0001_0000, 8'd24,  5'd12, MODE_BLOCK};
      3: r = '{32'h0000_3ffc, 8'd2,   5'd0,  MODE_READY};
      4: r = '{32'h8000_0040, 8'd16,  5'd31, MODE_RANDOM};
      5: r = '{32'h0002_0100, 8'd40,  5'd5,  MODE_BLOCK};
      6: r = '{32'hffff_ff00, 8'd3,   5'd18, MODE_READY};
      default: r = '{32'h0000_0800, 8'd255, 5'd9, MODE_RANDOM};
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) fail_now($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) fail_now($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_header(input dma_flit_t flit, input dma_hdr_t exp);
    if (flit.hdr !== exp) begin
      fail_now($sformatf("header %h (dest %0d src %0d class %0d size %0d), expected %h",
                         flit.hdr, flit.hdr.dest, flit.hdr.src, flit.hdr.pkt_class,
                         flit.hdr.size, exp));
    end
  endtask

  task automatic check_payload(input dma_flit_t flit, input logic last,
                               input logic [DMA_DATA_WIDTH-1:0] exp_word,
                               input logic exp_last);
    if (flit.payload !== exp_word || last !== exp_last) begin
      fail_now($sformatf("payload %h last %b, expected %h last %b",
                         flit.payload, last, exp_word, exp_last));
    end
  endtask

  task automatic check_addr(input logic [ADDR_WIDTH-1:0] addr, input logic [2:0] burst,
                            input logic [ADDR_WIDTH-1:0] exp_addr, input logic is_last);
    if (addr !== exp_addr) fail_now($sformatf("beat address %h, expected %h", addr, exp_addr));
    // Final word of the request must terminate the burst
    if (is_last && burst !== BURST_END) fail_now($sformatf("last beat burst code %b", burst));
  endtask

  task automatic check_burst(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) fail_now($sformatf("beat burst code %b, expected %b", got, exp));
  endtask

  //////////////////////////////////////////////////
  // Clock, memory model and network sink
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : drive_bus_noc
    int blk_cnt;
    blk_cnt   = 0;
    bus_ready = 1'b0;
    bus_rdata = '0;
    noc_ready = 1'b0;
    void'($urandom(91));
    forever begin
      @(posedge clk);
      #1;
      // About 70 percent ready, data follows the address rule
      bus_ready = ($urandom % 10) < 7;
      bus_rdata = bus_addr ^ 32'hC0DE_0000;
      blk_cnt++;
      case (cur_mode)
        MODE_READY:  noc_ready = 1'b1;
        MODE_RANDOM: noc_ready = ($urandom % 2) == 1;
        default:     noc_ready = (blk_cnt % 14) >= 10;
      endcase
    end
  end

  // Watchdog scaled to the table length
  initial begin : watchdog
    int   total;
    int   limit;
    row_t r;
    total = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = table_row(i);
      total += int'(r.size);
    end
    limit = 60 * total + 500;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired, run timed out after %0d cycles", limit);
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

  //////////////////////////////////////////////////
  // Per-cycle observation at the falling edge
  //////////////////////////////////////////////////

  task automatic observe_cycle();
    logic [DMA_DATA_WIDTH-1:0] exp_word;
    if (beats - flits > 3) fail_now($sformatf("%0d words held", beats - flits));
    check_bit(busy, 1'b1, "busy before the last flit");
    // A non-final beat ends the burst exactly when the select drops after it
    if (prev_beat && beats < cur_size) begin
      check_burst(prev_burst, bus_sel ? BURST_INCR : BURST_END);
    end
    if (bus_sel && bus_ready) begin
      if (beats >= cur_size) fail_now("bus beat beyond the last word");
      check_addr(bus_addr, bus_burst, cur_laddr + 32'(4 * beats), beats == cur_size - 1);
      beats++;
    end
    prev_beat  = bus_sel && bus_ready;
    prev_burst = bus_burst;
    // Track a burst that stops early and then resumes
    if (prev_sel && !bus_sel && beats < cur_size) mid_drop = 1'b1;
    if (!prev_sel && bus_sel && mid_drop) begin
      restarts++;
      mid_drop = 1'b0;
    end
    prev_sel = bus_sel;
    if (noc_valid && noc_ready) begin
      if (!got_hdr) begin
        check_header(noc_flit, exp_hdr);
        check_bit(noc_last, 1'b0, "noc_last on header");
        got_hdr = 1'b1;
      end else begin
        exp_word = (cur_laddr + 32'(4 * flits)) ^ 32'hC0DE_0000;
        check_payload(noc_flit, noc_last, exp_word, flits == cur_size - 1);
        flits++;
        got_last = noc_last;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    row_t r;
    rst       = 1'b1;
    req_start = 1'b0;
    req_size  = '0;
    req_laddr = '0;
    req_dest  = '0;
    cur_mode  = MODE_READY;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_bit(bus_sel, 1'b0, "bus_sel after reset");
    check_bit(bus_lock, 1'b0, "bus_lock after reset");
    check_bit(noc_valid, 1'b0, "noc_valid after reset");
    check_bit(noc_last, 1'b0, "noc_last after reset");
    check_bit(busy, 1'b0, "busy after reset");

    for (int i = 0; i < NUM_ROWS; i++) begin
      r         = table_row(i);
      cur_laddr = r.laddr;
      cur_size  = int'(r.size);
      cur_mode  = r.mode;
      beats     = 0;
      flits     = 0;
      restarts  = 0;
      got_hdr   = 1'b0;
      got_last  = 1'b0;
      mid_drop  = 1'b0;
      prev_sel  = 1'b0;
      prev_beat = 1'b0;
      exp_hdr           = '0;
      exp_hdr.dest      = r.dest;
      exp_hdr.src       = DMA_ID_WIDTH'(SRC_ID);
      exp_hdr.pkt_class = DMA_CLASS_DMA_DATA;
      exp_hdr.size      = r.size;
      // One-cycle start pulse with the row's fields
      @(posedge clk);
      #1;
      req_start = 1'b1;
      req_size  = r.size;
      req_laddr = r.laddr;
      req_dest  = r.dest;
      @(posedge clk);
      #1;
      req_start = 1'b0;
      @(negedge clk);
      check_bit(noc_valid, 1'b1, "header valid after start");
      observe_cycle();
      while (!got_last) begin
        @(negedge clk);
        observe_cycle();
      end
      // Request ends in the cycle after the last flit
      @(negedge clk);
      check_bit(busy, 1'b0, "busy after last flit");
      check_bit(bus_sel, 1'b0, "bus_sel after last flit");
      check_count(beats, cur_size, "bus beats");
      check_count(flits, cur_size, "payload flits");
      if (r.mode == MODE_BLOCK && restarts == 0) begin
        fail_now("bus burst never stopped and restarted under network stalls");
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- project.f
hdl/dma_pkg.sv
hdl/dma_read_fetch.sv
hdl/dma_word_fifo.sv
hdl/dma_noc_packetizer.sv
hdl/dma_read_top.sv
dv/dma_read_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA read testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module dma_read_tb \
  -Mdir obj_dir -o dma_read_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/dma_read_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
